// ==== dv/tb_clk_gen.sv ====
// --------------------
// CLKOP at 40 ns, reset high for the first 2 rising edges
// reset drops on a falling edge
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic CLKOP,
    output logic o_rst
);

    initial begin
        CLKOP = 1'b0;
        forever #20 CLKOP = ~CLKOP;     // 40 ns period
    end

    initial begin
        o_rst = 1'b1;
        repeat (2) @(posedge CLKOP);
        @(negedge CLKOP);               // release away from the sampling edge
        o_rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== dv/tb_uart_console.sv ====
// --------------------
// serial console testbench, drives 8N1 at the DUT bit rate
// each sent char is followed by a 3 frame gap, so no slot ever overflows
// --------------------
`timescale 1ns/1ps
`default_nettype none
`include "console_macros.svh"

module tb_uart_console;

    localparam int BIT_CYC   = `OVS * `TICK_DIV;   // CLKOP cycles per bit
    localparam int FRAME_CYC = 10 * BIT_CYC;
    localparam int GAP_CYC   = 3 * FRAME_CYC;      // echo + two hex chars
    localparam int N_SENT    = 50;                 // chars sent over all tests
    localparam int WD_CYC    = (N_SENT * 5 + 30) * FRAME_CYC;

    logic       CLKOP;
    logic       rst;
    logic       serial_in;
    logic       serial_out;
    logic [7:0] rx_q[$];     // decoded from the DUT line
    logic [7:0] exp_q[$];    // from the reference model
    int         errors;
    int         errs_start;
    int         n_checked;
    int         n_pass;
    int         n_fail;
    int         m_cnt;       // model digit count
    logic [7:0] m_a;
    logic [7:0] m_b;
    integer     seed;

    tb_clk_gen i_tb_clk_gen (.CLKOP(CLKOP), .o_rst(rst));

    uart_console i_uart_console (
        .CLKOP(CLKOP), .i_rst(rst), .i_serial_data(serial_in), .o_serial_data(serial_out)
    );

    // --------------------
    // reference model
    function automatic logic [7:0] hex_char(input logic [3:0] n);
        string digits;
        digits = "0123456789ABCDEF";
        return digits[n];
    endfunction

    // one sent char in, expected output bytes appended
    function automatic void ref_char(input logic [7:0] c);
        logic       is_dig;
        logic [7:0] r;
        is_dig = (c >= 8'h30) && (c <= 8'h39);
        if (c == `CHR_ESC) begin
            m_cnt = 0;                            // silent, drops state
        end else begin
            exp_q.push_back(c);                   // every other char echoes
            if (m_cnt == 2) begin
                if (c == `CHR_PLUS || c == `CHR_MINUS) begin
                    r = (c == `CHR_PLUS) ? (m_a + m_b) : (m_a - m_b);  // 8-bit wrap
                    exp_q.push_back(hex_char(r[7:4]));
                    exp_q.push_back(hex_char(r[3:0]));
                end
                m_cnt = 0;
            end else if (is_dig) begin
                if (m_cnt == 0) m_a = c - 8'h30;
                else m_b = c - 8'h30;
                m_cnt = m_cnt + 1;
            end else begin
                m_cnt = 0;                        // junk restarts
            end
        end
    endfunction

    // --------------------
    // stimulus
    task automatic send_byte(input logic [7:0] c);
        logic [9:0] frame;
        ref_char(c);
        frame = {1'b1, c, 1'b0};                  // stop, data, start
        for (int b = 0; b < 10; b++) begin
            @(negedge CLKOP);
            serial_in = frame[b];
            repeat (BIT_CYC - 1) @(negedge CLKOP);
        end
        repeat (GAP_CYC) @(negedge CLKOP);
    endtask

    task automatic send_str(input string s);
        for (int k = 0; k < s.len(); k++) begin
            send_byte(s[k]);
        end
    endtask

    // line high for two full frames
    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < 2 * FRAME_CYC) begin
            @(negedge CLKOP);
            if (serial_out) quiet++;
            else quiet = 0;
        end
    endtask

    task automatic begin_test();
        errs_start = errors;
        send_byte(`CHR_ESC);                      // known parser state
    endtask

    task automatic end_test(input string name);
        wait_idle();
        if (exp_q.size() != 0) begin
            errors++;
            $display("%s: %0d expected bytes never came out", name, exp_q.size());
            exp_q.delete();
        end
        if (errors == errs_start) begin
            n_pass++;
            $display("test %-12s ok", name);
        end else begin
            n_fail++;
            $display("test %-12s %0d errors", name, errors - errs_start);
        end
    endtask

    // --------------------
    // monitor, samples mid-bit on falling edges
    initial begin : serial_monitor
        logic [7:0] data;
        forever begin
            @(negedge CLKOP);
            if (!rst && serial_out === 1'b0) begin
                repeat (BIT_CYC / 2) @(negedge CLKOP);   // middle of start bit
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CYC) @(negedge CLKOP);
                    data[i] = serial_out;                // lsb first
                end
                repeat (BIT_CYC) @(negedge CLKOP);
                if (serial_out !== 1'b1) begin
                    errors++;
                    $display("output frame at %0t has a low stop bit", $time);
                end else begin
                    rx_q.push_back(data);
                end
            end
        end
    end

    // compare, on rising edges so the monitor's push has settled
    initial begin : compare_proc
        logic [7:0] got;
        logic [7:0] want;
        forever begin
            @(posedge CLKOP);
            while (rx_q.size() != 0) begin
                got = rx_q.pop_front();
                n_checked++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERR %0t: unexpected byte 0x%02h", $time, got);
                end else begin
                    want = exp_q.pop_front();
                    if (got !== want) begin
                        errors++;
                        $display("ERR %0t: expected 0x%02h, got 0x%02h", $time, want, got);
                    end
                end
            end
        end
    end

    // watchdog
    initial begin
        repeat (WD_CYC) @(posedge CLKOP);
        $display("run timed out after %0d clock cycles", WD_CYC);
        $display("Simulation FAILED");
        $finish;
    end

    // --------------------
    // test sequence
    initial begin : main_seq
        logic [7:0] c;
        logic       seen_low;
        serial_in = 1'b1;                         // idle line
        errors = 0;
        n_checked = 0;
        n_pass = 0;
        n_fail = 0;
        m_cnt = 0;
        m_a = 8'h00;
        m_b = 8'h00;
        seed = 13;
        @(negedge CLKOP);
        wait (rst == 1'b0);

        // 1: quiet line after reset
        errs_start = errors;
        seen_low = 1'b0;
        repeat (2 * FRAME_CYC) begin
            @(negedge CLKOP);
            if (serial_out !== 1'b1) seen_low = 1'b1;
        end
        if (seen_low) begin
            errors++;
            $display("ERR %0t: output left idle after reset", $time);
        end
        end_test("reset_idle");

        // 2: random printable echo
        begin_test();
        for (int k = 0; k < 20; k++) begin
            c = 8'(32 + ($unsigned($random(seed)) % 95));  // 0x20..0x7E
            send_byte(c);
        end
        end_test("rand_echo");

        begin_test();
        send_str("34+");                          // 07
        end_test("add");

        begin_test();
        send_str("29-");                          // F9
        send_str("99+");                          // 12
        end_test("sub_carry");

        begin_test();
        send_str("1");
        send_byte(`CHR_ESC);
        send_str("23+");                          // 05
        end_test("esc_clear");

        begin_test();
        send_str("5x67+");                        // 0D
        send_str("44*");                          // no result
        send_str("11+");                          // 02
        end_test("junk_chars");

        $display("tests: %0d passed, %0d failed, %0d bytes checked, %0d errors",
                 n_pass, n_fail, n_checked, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the uart_console testbench with Verilator
# exit status is non-zero on a build error, a crash or a failing run

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f uart_console.f --top-module tb_uart_console \
    -Mdir obj_dir -o tb_uart_console
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/tb_uart_console > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== source/baud_gen.sv ====
// --------------------
// oversample tick, one CLKOP cycle wide
// TICK_DIV must be 2 or more
// --------------------
`timescale 1ns/1ps
`default_nettype none
`include "console_macros.svh"

module baud_gen (
    input  wire  CLKOP,
    input  wire  i_rst,
    output logic o_tick
);

    localparam int CNT_W = $clog2(`TICK_DIV);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`TICK_DIV - 1);

    logic [CNT_W-1:0] div_cnt;  // wraps every TICK_DIV cycles

    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            div_cnt <= '0;
            o_tick  <= 1'b0;
        end else begin
            o_tick <= (div_cnt == CNT_LAST);     // one pulse per wrap
            if (div_cnt == CNT_LAST) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/cmd_parser.sv ====
// --------------------
// digit, digit, '+'/'-' -> 8-bit two's complement result
// single-digit operands only, ESC clears state
// --------------------
`timescale 1ns/1ps
`default_nettype none
`include "console_macros.svh"

module cmd_parser (
    input  wire                   CLKOP,
    input  wire                   i_rst,
    input  wire                   i_rx_stb,
    input  console_pkg::rx_char_u i_rx_char,
    output logic                  o_echo_stb,
    output logic [7:0]            o_echo_char,
    output logic                  o_res_stb,
    output logic [7:0]            o_res_byte,
    output logic                  o_flush
);

    logic [1:0] dig_cnt;   // digits held, 0..2
    logic [3:0] op_a;      // first digit
    logic [3:0] op_b;      // second digit
    logic       is_esc;
    logic       is_plus;
    logic       is_minus;
    logic       is_digit;

    // --------------------
    // classify
    assign is_esc   = (i_rx_char.raw == `CHR_ESC);
    assign is_plus  = (i_rx_char.raw == `CHR_PLUS);
    assign is_minus = (i_rx_char.raw == `CHR_MINUS);
    assign is_digit = (i_rx_char.nib.zone == `DIGIT_ZONE) && (i_rx_char.nib.value <= 4'd9);

    // --------------------
    // control
    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            dig_cnt    <= 2'd0;
            o_echo_stb <= 1'b0;
            o_res_stb  <= 1'b0;
            o_flush    <= 1'b0;
        end else begin
            o_echo_stb <= i_rx_stb & ~is_esc;              // everything but ESC
            o_flush    <= i_rx_stb & is_esc;
            o_res_stb  <= i_rx_stb & (dig_cnt == 2'd2) & (is_plus | is_minus);
            if (i_rx_stb) begin
                if (is_esc || dig_cnt == 2'd2) begin
                    dig_cnt <= 2'd0;                       // any 3rd char ends the cmd
                end else if (is_digit) begin
                    dig_cnt <= dig_cnt + 2'd1;
                end else begin
                    dig_cnt <= 2'd0;                       // junk restarts
                end
            end
        end
    end

    // --------------------
    // payload, no reset
    always_ff @(posedge CLKOP) begin
        if (i_rx_stb) begin
            o_echo_char <= i_rx_char.raw;
            if (is_digit && dig_cnt == 2'd0) op_a <= i_rx_char.nib.value;
            if (is_digit && dig_cnt == 2'd1) op_b <= i_rx_char.nib.value;
            if (dig_cnt == 2'd2) begin
                if (is_minus) begin
                    o_res_byte <= {4'd0, op_a} - {4'd0, op_b};  // wraps, 2-9 -> 0xF9
                end else begin
                    o_res_byte <= {4'd0, op_a} + {4'd0, op_b};
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/console_macros.svh ====
// --------------------
// console constants, included where needed
// char codes are 8-bit ASCII, line is 8N1 only
// --------------------
`ifndef CONSOLE_MACROS_SVH
`define CONSOLE_MACROS_SVH

// --------------------
// timing
`define TICK_DIV       4        // CLKOP cycles per oversample tick
`define OVS            16       // oversample ticks per bit
`define DATA_BITS      8        // no parity, one stop bit

// --------------------
// character codes
`define CHR_ESC        8'h1B    // soft reset, never echoed
`define CHR_PLUS       8'h2B
`define CHR_MINUS      8'h2D
`define DIGIT_ZONE     4'h3     // upper nibble of '0'..'9'

// nibbles 10..15 -> 'A'..'F'
`define HEX_ALPHA_BASE 8'h37

`endif

// ==== source/console_pkg.sv ====
// --------------------
// shared type for the received character
// --------------------
`default_nettype none

package console_pkg;

    // same byte, seen whole or as zone/value nibbles
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] zone;   // upper nibble
            logic [3:0] value;  // lower nibble
        } nib;
    } rx_char_u;

endpackage

`default_nettype wire

// ==== source/tx_arbiter.sv ====
// --------------------
// echo slot (1 deep) before result slot (2 hex chars)
// echo dropped if slot full, new result replaces old
// --------------------
`timescale 1ns/1ps
`default_nettype none
`include "console_macros.svh"

module tx_arbiter (
    input  wire        CLKOP,
    input  wire        i_rst,
    input  wire        i_echo_stb,
    input  wire  [7:0] i_echo_char,
    input  wire        i_res_stb,
    input  wire  [7:0] i_res_byte,
    input  wire        i_flush,
    input  wire        i_tx_busy,
    output logic       o_tx_stb,
    output logic [7:0] o_tx_byte
);

    import console_pkg::*;

    logic       echo_full;
    logic [7:0] echo_q;
    logic [1:0] res_left;   // hex chars still to send, 2 = high next
    rx_char_u   res_q;      // zone = high nibble, value = low nibble
    logic       can_send;   // busy lags the strobe by one cycle
    logic       echo_take;
    logic       res_take;
    logic [3:0] res_nib;

    function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
        if (nib < 4'd10) return 8'h30 + {4'd0, nib};
        return `HEX_ALPHA_BASE + {4'd0, nib};
    endfunction

    assign can_send  = ~i_tx_busy & ~o_tx_stb;
    assign echo_take = can_send & echo_full;
    assign res_take  = can_send & ~echo_full & (res_left != 2'd0);
    assign res_nib   = (res_left == 2'd2) ? res_q.nib.zone : res_q.nib.value;

    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            echo_full <= 1'b0;
            res_left  <= 2'd0;
            o_tx_stb  <= 1'b0;
        end else begin
            o_tx_stb <= echo_take | res_take;
            if (echo_take) echo_full <= 1'b0;
            if (i_echo_stb) echo_full <= 1'b1;        // refill or stay full
            if (res_take) res_left <= res_left - 2'd1;
            if (i_flush) res_left <= 2'd0;            // ESC drops pending hex
            if (i_res_stb) res_left <= 2'd2;
        end
    end

    // payload, no reset
    always_ff @(posedge CLKOP) begin
        if (i_echo_stb && (!echo_full || echo_take)) echo_q <= i_echo_char;
        if (i_res_stb) res_q.raw <= i_res_byte;
        if (echo_take) begin
            o_tx_byte <= echo_q;
        end else if (res_take) begin
            o_tx_byte <= hex_ascii(res_nib);
        end
    end

endmodule

`default_nettype wire

// ==== source/uart_console.sv ====
// --------------------
// serial calculator console top
// rx -> parser -> arbiter -> tx, one clock
// --------------------
`timescale 1ns/1ps
`default_nettype none

module uart_console (
    input  wire  CLKOP,
    input  wire  i_rst,
    input  wire  i_serial_data,
    output logic o_serial_data
);

    import console_pkg::*;

    logic       tick;       // 16x oversample
    logic       rx_stb;
    rx_char_u   rx_char;
    logic       echo_stb;
    logic [7:0] echo_char;
    logic       res_stb;
    logic [7:0] res_byte;
    logic       flush;      // ESC seen
    logic       tx_stb;
    logic [7:0] tx_byte;
    logic       tx_busy;

    baud_gen i_baud_gen (.CLKOP(CLKOP), .i_rst(i_rst), .o_tick(tick));

    uart_rx i_uart_rx (
        .CLKOP(CLKOP), .i_rst(i_rst), .i_tick(tick), .i_serial_data(i_serial_data),
        .o_rx_stb(rx_stb), .o_rx_char(rx_char)
    );

    cmd_parser i_cmd_parser (
        .CLKOP(CLKOP), .i_rst(i_rst), .i_rx_stb(rx_stb), .i_rx_char(rx_char),
        .o_echo_stb(echo_stb), .o_echo_char(echo_char),
        .o_res_stb(res_stb), .o_res_byte(res_byte), .o_flush(flush)
    );

    tx_arbiter i_tx_arbiter (
        .CLKOP(CLKOP), .i_rst(i_rst), .i_echo_stb(echo_stb), .i_echo_char(echo_char),
        .i_res_stb(res_stb), .i_res_byte(res_byte), .i_flush(flush),
        .i_tx_busy(tx_busy), .o_tx_stb(tx_stb), .o_tx_byte(tx_byte)
    );

    uart_tx i_uart_tx (
        .CLKOP(CLKOP), .i_rst(i_rst), .i_tick(tick), .i_tx_stb(tx_stb),
        .i_tx_byte(tx_byte), .o_tx_busy(tx_busy), .o_serial_data(o_serial_data)
    );

endmodule

`default_nettype wire

// ==== source/uart_rx.sv ====
// --------------------
// 8N1 receiver, bits sampled once at mid-bit
// bad stop bit drops the byte silently
// --------------------
`timescale 1ns/1ps
`default_nettype none
`include "console_macros.svh"

module uart_rx (
    input  wire                   CLKOP,
    input  wire                   i_rst,
    input  wire                   i_tick,
    input  wire                   i_serial_data,
    output logic                  o_rx_stb,
    output console_pkg::rx_char_u o_rx_char
);

    import console_pkg::*;

    localparam int TCNT_W = $clog2(`OVS);
    localparam int BCNT_W = $clog2(`DATA_BITS);
    localparam logic [TCNT_W-1:0] TICK_HALF = TCNT_W'(`OVS / 2 - 1);
    localparam logic [TCNT_W-1:0] TICK_LAST = TCNT_W'(`OVS - 1);
    localparam logic [BCNT_W-1:0] BIT_LAST  = BCNT_W'(`DATA_BITS - 1);

    // fsm states
    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic [2:0]        sync_q;    // [1:0] sync, [2] previous
    logic [1:0]        state;
    logic [TCNT_W-1:0] tick_cnt;
    logic [BCNT_W-1:0] bit_cnt;
    rx_char_u          shift_q;   // assembled LSB first
    logic              rx_line;
    logic              start_edge;

    assign rx_line    = sync_q[1];
    assign start_edge = sync_q[2] & ~sync_q[1];  // high to low

    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            sync_q   <= 3'b111;   // idle line is high
            state    <= S_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_rx_stb <= 1'b0;
        end else begin
            sync_q   <= {sync_q[1:0], i_serial_data};
            o_rx_stb <= 1'b0;
            case (state)
                S_IDLE: begin
                    tick_cnt <= '0;
                    if (start_edge) state <= S_START;
                end
                S_START: if (i_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == TICK_HALF) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_line ? S_IDLE : S_DATA;  // glitch -> back to idle
                    end
                end
                S_DATA: if (i_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == TICK_LAST) begin
                        tick_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_LAST) state <= S_STOP;
                    end
                end
                default: if (i_tick) begin       // stop bit
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == TICK_LAST) begin
                        o_rx_stb <= rx_line;     // framing check
                        state    <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // payload, no reset
    always_ff @(posedge CLKOP) begin
        if (state == S_DATA && i_tick && tick_cnt == TICK_LAST) begin
            shift_q.raw <= {rx_line, shift_q.raw[7:1]};
        end
        if (state == S_STOP && i_tick && tick_cnt == TICK_LAST && rx_line) begin
            o_rx_char <= shift_q;                // held until next strobe
        end
    end

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
// --------------------
// 8N1 transmitter, LSB first
// strobe ignored while busy, no queue here
// --------------------
`timescale 1ns/1ps
`default_nettype none
`include "console_macros.svh"

module uart_tx (
    input  wire                  CLKOP,
    input  wire                  i_rst,
    input  wire                  i_tick,
    input  wire                  i_tx_stb,
    input  wire [`DATA_BITS-1:0] i_tx_byte,
    output logic                 o_tx_busy,
    output logic                 o_serial_data
);

    localparam int FRAME_BITS = `DATA_BITS + 2;  // start + data + stop
    localparam int TCNT_W     = $clog2(`OVS);
    localparam int BCNT_W     = $clog2(FRAME_BITS);
    localparam logic [TCNT_W-1:0] TICK_LAST = TCNT_W'(`OVS - 1);
    localparam logic [BCNT_W-1:0] BIT_LAST  = BCNT_W'(FRAME_BITS - 1);

    logic [FRAME_BITS-1:0] frame_q;   // bit 0 goes out next
    logic [TCNT_W-1:0]     tick_cnt;
    logic [BCNT_W-1:0]     bit_cnt;
    logic                  load;
    logic                  bit_edge;  // first tick of a bit

    assign load     = i_tx_stb & ~o_tx_busy;
    assign bit_edge = o_tx_busy & i_tick & (tick_cnt == '0);

    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            o_tx_busy     <= 1'b0;
            o_serial_data <= 1'b1;     // idle high
            tick_cnt      <= '0;
            bit_cnt       <= '0;
        end else if (load) begin
            o_tx_busy <= 1'b1;         // busy from the cycle after the strobe
            tick_cnt  <= '0;
            bit_cnt   <= '0;
        end else if (o_tx_busy && i_tick) begin
            if (bit_edge) o_serial_data <= frame_q[0];
            tick_cnt <= tick_cnt + 1'b1;
            if (tick_cnt == TICK_LAST) begin
                tick_cnt <= '0;
                if (bit_cnt == BIT_LAST) begin
                    o_tx_busy <= 1'b0;             // stop bit done
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // shift register, no reset
    always_ff @(posedge CLKOP) begin
        if (load) begin
            frame_q <= {1'b1, i_tx_byte, 1'b0};
        end else if (bit_edge) begin
            frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

// ==== uart_console.f ====
+incdir+source
source/console_pkg.sv
source/baud_gen.sv
source/uart_rx.sv
source/uart_tx.sv
source/cmd_parser.sv
source/tx_arbiter.sv
source/uart_console.sv
dv/tb_clk_gen.sv
dv/tb_uart_console.sv
